// File: src.f
+incdir+.
yolo_read_pkg.sv
yolo_read_ctrl.sv
yolo_fetch.sv
yolo_bus_merge.sv
yolo_lane_mem.sv
yolo_read_addrgen.sv
yolo_bias_store.sv
yolo_read.sv
yolo_read_sva.sv
yolo_read_tb.sv

// File: yolo_bias_store.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_bias_store import yolo_read_pkg::*; (
   input  logic                    clk,
   input  mem_wr_t                 wr,
   input  logic [`BIAS_ADDR_W-1:0] r_addr,
   output logic [`DATABUS_W-1:0]   bias
);

   logic [`DATABUS_W-1:0] mem [2**`BIAS_ADDR_W];
   bus_word_u             in_word;
   bus_word_u             rev_word;

   // output lane 0 takes the last fetched slot
   always_comb begin
      in_word.word = wr.data;
      for (int i = 0; i < `N_VECT; i++) begin
         rev_word.lane[i] = in_word.lane[`N_VECT-1-i];
      end
   end

   // only the low address bits reach the small bias memory
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr[`BIAS_ADDR_W-1:0]] <= rev_word.word;
      end
   end

   always_ff @(posedge clk) begin
      bias <= mem[r_addr];
   end

endmodule

// File: yolo_bus_merge.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_bus_merge import yolo_read_pkg::*; (
   input  bus_req_t  reqs  [`N_VECT+1],
   output bus_resp_t resps [`N_VECT+1],
   output bus_req_t  bus_req,
   input  bus_resp_t bus_resp
);

   logic [`N_VECT:0] grant;

   // lowest index wins, bias engine sits last
   always_comb begin
      logic taken;
      taken = 1'b0;
      grant = '0;
      for (int i = 0; i <= `N_VECT; i++) begin
         if (reqs[i].valid && !taken) begin
            grant[i] = 1'b1;
            taken    = 1'b1;
         end
      end
   end

   always_comb begin
      bus_req = '0;
      for (int i = 0; i <= `N_VECT; i++) begin
         if (grant[i]) bus_req = reqs[i];
      end
   end

   // rdata goes to everyone, ready only to the winner
   always_comb begin
      for (int i = 0; i <= `N_VECT; i++) begin
         resps[i].rdata = bus_resp.rdata;
         resps[i].ready = grant[i] && bus_resp.ready;
      end
   end

endmodule

// File: yolo_fetch.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_fetch import yolo_read_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  logic [`EXT_ADDR_W-1:0]   base,
   input  logic [`LEN_W-1:0]        len,
   input  logic [`W_MEM_ADDR_W-1:0] int_addr,
   output bus_req_t                 req,
   input  bus_resp_t                resp,
   output mem_wr_t                  wr,
   output logic                     done
);

   logic                     busy;
   logic                     xfer;
   logic [`EXT_ADDR_W-1:0]   ext_addr;
   logic [`LEN_W-1:0]        remain;
   logic [`W_MEM_ADDR_W-1:0] next_waddr;
   logic                     wr_en;
   logic [`W_MEM_ADDR_W-1:0] wr_addr;
   logic [`DATABUS_W-1:0]    wr_data;

   // a transfer completes when ready meets our request
   assign xfer = busy && resp.ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy   <= 1'b0;
         remain <= '0;
         wr_en  <= 1'b0;
      end else begin
         wr_en <= xfer;
         if (!busy && start) begin
            // zero length finishes straight away
            busy   <= (len != '0);
            remain <= len;
         end else if (xfer) begin
            remain <= remain - 1'b1;
            if (remain == 1) busy <= 1'b0;
         end
      end
   end

   // address and write data path
   always_ff @(posedge clk) begin
      if (!busy && start) begin
         ext_addr   <= base;
         next_waddr <= int_addr;
      end else if (xfer) begin
         ext_addr   <= ext_addr + `BUS_BYTES;
         next_waddr <= next_waddr + 1'b1;
      end
      if (xfer) begin
         wr_addr <= next_waddr;
         wr_data <= resp.rdata;
      end
   end

   assign req  = '{valid: busy, addr: ext_addr};
   assign wr   = '{en: wr_en, addr: wr_addr, data: wr_data};
   // hold off done until the last word is in memory
   assign done = !busy && !wr_en;

endmodule

// File: yolo_lane_mem.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_lane_mem import yolo_read_pkg::*; (
   input  logic                   clk,
   input  mem_wr_t                wr,
   input  logic                   r_en,
   input  logic [`R_ADDR_W-1:0]   r_addr,
   output logic [`DATAPATH_W-1:0] rdata
);

   localparam int SLOT_W = `R_ADDR_W - `W_MEM_ADDR_W;

   bus_word_u                mem [2**`W_MEM_ADDR_W];
   logic [`W_MEM_ADDR_W-1:0] word_addr;
   logic [SLOT_W-1:0]        slot;
   logic [`DATAPATH_W-1:0]   rd_q;

   // upper bits pick the word, low bits the lane slot
   assign word_addr = r_addr[`R_ADDR_W-1 -: `W_MEM_ADDR_W];
   assign slot      = r_addr[SLOT_W-1:0];

   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   always_ff @(posedge clk) begin
      if (r_en) begin
         rd_q <= mem[word_addr].lane[slot];
      end
   end

   // output register as second stage of the read
   always_ff @(posedge clk) begin
      rdata <= rd_q;
   end

endmodule

// File: yolo_read.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_read import yolo_read_pkg::*; (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                clear,
   input  logic                                run,
   input  cpu_wr_t                             cpu,
   output bus_req_t                            bus_req,
   input  bus_resp_t                           bus_resp,
   output logic [`N_VECT-1:0][`DATAPATH_W-1:0] flow_out_weight,
   output logic [`DATABUS_W-1:0]               flow_out_bias,
   output logic                                flow_valid,
   output logic                                done
);

   logic [`N_VECT-1:0][`EXT_ADDR_W-1:0] lane_base;
   logic [`EXT_ADDR_W-1:0]              bias_base;
   logic [`LEN_W-1:0]                   len;
   logic [`W_MEM_ADDR_W-1:0]            int_addr;
   logic [`BIAS_ADDR_W-1:0]             bias_int_addr;
   logic [`BIAS_ADDR_W-1:0]             bias_start;
   read_cfg_t                           rcfg;
   logic                                fetch_start;
   logic                                read_start;
   logic                                read_done;
   logic [`N_VECT:0]                    fetch_done;

   // engine N_VECT is the bias engine
   bus_req_t                            reqs  [`N_VECT+1];
   bus_resp_t                           resps [`N_VECT+1];
   mem_wr_t                             wrs   [`N_VECT+1];

   logic                                r_en;
   logic [`R_ADDR_W-1:0]                r_addr;

   yolo_read_ctrl ctrl0 (
      .clk           (clk),
      .rst           (rst),
      .clear         (clear),
      .run           (run),
      .cpu           (cpu),
      .fetch_done    (fetch_done),
      .read_done     (read_done),
      .lane_base     (lane_base),
      .bias_base     (bias_base),
      .len           (len),
      .int_addr      (int_addr),
      .bias_int_addr (bias_int_addr),
      .bias_start    (bias_start),
      .rcfg          (rcfg),
      .fetch_start   (fetch_start),
      .read_start    (read_start),
      .done          (done)
   );

   for (genvar i = 0; i < `N_VECT; i++) begin : g_lane
      yolo_fetch fetch0 (
         .clk      (clk),
         .rst      (rst),
         .start    (fetch_start),
         .base     (lane_base[i]),
         .len      (len),
         .int_addr (int_addr),
         .req      (reqs[i]),
         .resp     (resps[i]),
         .wr       (wrs[i]),
         .done     (fetch_done[i])
      );

      yolo_lane_mem mem0 (
         .clk    (clk),
         .wr     (wrs[i]),
         .r_en   (r_en),
         .r_addr (r_addr),
         .rdata  (flow_out_weight[i])
      );
   end

   yolo_fetch bias_fetch0 (
      .clk      (clk),
      .rst      (rst),
      .start    (fetch_start),
      .base     (bias_base),
      .len      (len),
      .int_addr ({{(`W_MEM_ADDR_W-`BIAS_ADDR_W){1'b0}}, bias_int_addr}),
      .req      (reqs[`N_VECT]),
      .resp     (resps[`N_VECT]),
      .wr       (wrs[`N_VECT]),
      .done     (fetch_done[`N_VECT])
   );

   yolo_bus_merge merge0 (
      .reqs     (reqs),
      .resps    (resps),
      .bus_req  (bus_req),
      .bus_resp (bus_resp)
   );

   yolo_read_addrgen addrgen0 (
      .clk        (clk),
      .rst        (rst),
      .start      (read_start),
      .cfg        (rcfg),
      .r_en       (r_en),
      .r_addr     (r_addr),
      .flow_valid (flow_valid),
      .done       (read_done)
   );

   yolo_bias_store bias0 (
      .clk    (clk),
      .wr     (wrs[`N_VECT]),
      .r_addr (bias_start),
      .bias   (flow_out_bias)
   );

endmodule

// File: yolo_read_addrgen.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_read_addrgen import yolo_read_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  read_cfg_t            cfg,
   output logic                 r_en,
   output logic [`R_ADDR_W-1:0] r_addr,
   output logic                 flow_valid,
   output logic                 done
);

   logic [`R_ADDR_W-1:0] iter_cnt;
   logic [`R_ADDR_W-1:0] per_cnt;
   // first address of the current iteration
   logic [`R_ADDR_W-1:0] line_addr;
   logic                 valid_d1;
   logic                 valid_d2;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         r_en      <= 1'b0;
         r_addr    <= '0;
         line_addr <= '0;
         iter_cnt  <= '0;
         per_cnt   <= '0;
      end else if (start && !r_en) begin
         r_en      <= (cfg.iter != '0) && (cfg.per != '0);
         r_addr    <= cfg.start;
         line_addr <= cfg.start;
         iter_cnt  <= '0;
         per_cnt   <= '0;
      end else if (r_en) begin
         if (per_cnt == cfg.per - 1'b1) begin
            per_cnt <= '0;
            if (iter_cnt == cfg.iter - 1'b1) begin
               r_en <= 1'b0;
            end else begin
               iter_cnt  <= iter_cnt + 1'b1;
               line_addr <= line_addr + cfg.shift;
               r_addr    <= line_addr + cfg.shift;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            r_addr  <= r_addr + cfg.incr;
         end
      end
   end

   // memory read, then lane output register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_d1 <= 1'b0;
         valid_d2 <= 1'b0;
      end else begin
         valid_d1 <= r_en;
         valid_d2 <= valid_d1;
      end
   end

   assign flow_valid = valid_d2;
   assign done       = !r_en && !valid_d1 && !valid_d2;

endmodule

// File: yolo_read_ctrl.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_read_ctrl import yolo_read_pkg::*; (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                clear,
   input  logic                                run,
   input  cpu_wr_t                             cpu,
   input  logic [`N_VECT:0]                    fetch_done,
   input  logic                                read_done,
   output logic [`N_VECT-1:0][`EXT_ADDR_W-1:0] lane_base,
   output logic [`EXT_ADDR_W-1:0]              bias_base,
   output logic [`LEN_W-1:0]                   len,
   output logic [`W_MEM_ADDR_W-1:0]            int_addr,
   output logic [`BIAS_ADDR_W-1:0]             bias_int_addr,
   output logic [`BIAS_ADDR_W-1:0]             bias_start,
   output read_cfg_t                           rcfg,
   output logic                                fetch_start,
   output logic                                read_start,
   output logic                                done
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_FETCH = 2'd1;
   localparam logic [1:0] ST_READ  = 2'd2;

   logic [1:0]                          state;
   logic                                run_ok;
   logic                                fetch_end;

   // cpu visible configuration
   logic [`EXT_ADDR_W-1:0]              cfg_ext_addr;
   logic [`EXT_ADDR_W-1:0]              cfg_offset;
   logic [`LEN_W-1:0]                   cfg_len;
   logic [`W_MEM_ADDR_W-1:0]            cfg_int_addr;
   read_cfg_t                           cfg_read;
   logic [`EXT_ADDR_W-1:0]              cfg_bias_ext_addr;
   logic [`BIAS_ADDR_W-1:0]             cfg_bias_int_addr;
   logic [`BIAS_ADDR_W-1:0]             cfg_bias_start;

   logic [`N_VECT-1:0][`EXT_ADDR_W-1:0] base_calc;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_ext_addr      <= '0;
         cfg_offset        <= '0;
         cfg_len           <= '0;
         cfg_int_addr      <= '0;
         cfg_read          <= '0;
         cfg_bias_ext_addr <= '0;
         cfg_bias_int_addr <= '0;
         cfg_bias_start    <= '0;
      end else if (clear) begin
         cfg_ext_addr      <= '0;
         cfg_offset        <= '0;
         cfg_len           <= '0;
         cfg_int_addr      <= '0;
         cfg_read          <= '0;
         cfg_bias_ext_addr <= '0;
         cfg_bias_int_addr <= '0;
         cfg_bias_start    <= '0;
      end else if (cpu.valid) begin
         case (cpu.addr)
            `CONF_EXT_ADDR:      cfg_ext_addr      <= cpu.wdata;
            `CONF_OFFSET:        cfg_offset        <= cpu.wdata;
            `CONF_LEN:           cfg_len           <= cpu.wdata[`LEN_W-1:0];
            `CONF_INT_ADDR:      cfg_int_addr      <= cpu.wdata[`W_MEM_ADDR_W-1:0];
            `CONF_ITER:          cfg_read.iter     <= cpu.wdata[`R_ADDR_W-1:0];
            `CONF_PER:           cfg_read.per      <= cpu.wdata[`R_ADDR_W-1:0];
            `CONF_START:         cfg_read.start    <= cpu.wdata[`R_ADDR_W-1:0];
            `CONF_SHIFT:         cfg_read.shift    <= cpu.wdata[`R_ADDR_W-1:0];
            `CONF_INCR:          cfg_read.incr     <= cpu.wdata[`R_ADDR_W-1:0];
            `CONF_BIAS_EXT_ADDR: cfg_bias_ext_addr <= cpu.wdata;
            `CONF_BIAS_INT_ADDR: cfg_bias_int_addr <= cpu.wdata[`BIAS_ADDR_W-1:0];
            `CONF_BIAS_START:    cfg_bias_start    <= cpu.wdata[`BIAS_ADDR_W-1:0];
            default: ;
         endcase
      end
   end

   // running adder puts lane i at i offsets above the base
   always_comb begin
      base_calc[0] = cfg_ext_addr;
      for (int i = 1; i < `N_VECT; i++) begin
         base_calc[i] = base_calc[i-1] + cfg_offset;
      end
   end

   // runs are only taken while idle
   assign run_ok = run && (state == ST_IDLE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         lane_base     <= '0;
         bias_base     <= '0;
         len           <= '0;
         int_addr      <= '0;
         bias_int_addr <= '0;
         bias_start    <= '0;
         rcfg          <= '0;
      end else if (run_ok) begin
         lane_base     <= base_calc;
         bias_base     <= cfg_bias_ext_addr;
         len           <= cfg_len;
         int_addr      <= cfg_int_addr;
         bias_int_addr <= cfg_bias_int_addr;
         bias_start    <= cfg_bias_start;
         rcfg          <= cfg_read;
      end
   end

   // engines still show done while fetch_start is high
   assign fetch_end  = (state == ST_FETCH) && !fetch_start && (&fetch_done);
   assign read_start = fetch_end;
   assign done       = (state == ST_IDLE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= ST_IDLE;
         fetch_start <= 1'b0;
      end else begin
         fetch_start <= run_ok;
         case (state)
            ST_IDLE: begin
               if (run_ok) state <= ST_FETCH;
            end
            ST_FETCH: begin
               if (fetch_end) state <= ST_READ;
            end
            ST_READ: begin
               if (read_done) state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

// File: yolo_read_macros.svh
`ifndef YOLO_READ_MACROS_SVH
`define YOLO_READ_MACROS_SVH

// datapath geometry
`define N_VECT       4
`define DATAPATH_W   32
`define DATABUS_W    (`N_VECT * `DATAPATH_W)
`define EXT_ADDR_W   32
`define BUS_BYTES    16
`define LEN_W        16
`define W_MEM_ADDR_W 6
`define R_ADDR_W     (`W_MEM_ADDR_W + 2)
`define BIAS_ADDR_W  4
`define CONF_ADDR_W  4

// configuration register map
`define CONF_EXT_ADDR      0
`define CONF_OFFSET        1
`define CONF_LEN           2
`define CONF_INT_ADDR      3
`define CONF_ITER          4
`define CONF_PER           5
`define CONF_START         6
`define CONF_SHIFT         7
`define CONF_INCR          8
`define CONF_BIAS_EXT_ADDR 9
`define CONF_BIAS_INT_ADDR 10
`define CONF_BIAS_START    11

`endif

// File: yolo_read_pkg.sv
`include "yolo_read_macros.svh"

package yolo_read_pkg;

   // cpu configuration write strobe
   typedef struct packed {
      logic                     valid;
      logic [`CONF_ADDR_W-1:0]  addr;
      logic [`EXT_ADDR_W-1:0]   wdata;
   } cpu_wr_t;

   // databus request held until ready
   typedef struct packed {
      logic                     valid;
      logic [`EXT_ADDR_W-1:0]   addr;
   } bus_req_t;

   typedef struct packed {
      logic                     ready;
      logic [`DATABUS_W-1:0]    rdata;
   } bus_resp_t;

   // local memory write port
   typedef struct packed {
      logic                     en;
      logic [`W_MEM_ADDR_W-1:0] addr;
      logic [`DATABUS_W-1:0]    data;
   } mem_wr_t;

   typedef struct packed {
      logic [`R_ADDR_W-1:0]     iter;
      logic [`R_ADDR_W-1:0]     per;
      logic [`R_ADDR_W-1:0]     start;
      logic [`R_ADDR_W-1:0]     shift;
      logic [`R_ADDR_W-1:0]     incr;
   } read_cfg_t;

   // one bus word seen whole or as datapath lanes
   typedef union packed {
      logic [`DATABUS_W-1:0]                   word;
      logic [`N_VECT-1:0][`DATAPATH_W-1:0]     lane;
   } bus_word_u;

endpackage

// File: yolo_read_sva.sv
`timescale 1ns/1ps

module yolo_read_sva import yolo_read_pkg::*; (
   input logic      clk,
   input logic      rst,
   input logic      clear,
   input logic      run,
   input cpu_wr_t   cpu,
   input bus_req_t  bus_req,
   input bus_resp_t bus_resp,
   input logic      flow_valid,
   input logic      done
);

   int   fail_count = 0;
   logic cleared;
   logic clean_run;

   // tracks a run that starts from cleared registers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cleared   <= 1'b0;
         clean_run <= 1'b0;
      end else begin
         if (clear) cleared <= 1'b1;
         else if (cpu.valid) cleared <= 1'b0;
         if (run && done && cleared) clean_run <= 1'b1;
         else if (done) clean_run <= 1'b0;
      end
   end

   a_reset_idle: assert property (@(posedge clk) rst |-> done && !bus_req.valid && !flow_valid)
      else begin fail_count++; $error("DUT not idle during reset"); end

   a_run_done: assert property (@(posedge clk) disable iff (rst) run && done |=> !done)
      else begin fail_count++; $error("done did not fall after run"); end

   a_req_hold: assert property (@(posedge clk) disable iff (rst)
      bus_req.valid && !bus_resp.ready |=> bus_req.valid && $stable(bus_req.addr))
      else begin fail_count++; $error("bus request dropped or changed before ready"); end

   a_bus_busy: assert property (@(posedge clk) disable iff (rst) bus_req.valid |-> !done)
      else begin fail_count++; $error("done high while a bus request is pending"); end

   a_flow_busy: assert property (@(posedge clk) disable iff (rst) flow_valid |-> !done)
      else begin fail_count++; $error("done high while weights are still flowing"); end

   a_clean_quiet: assert property (@(posedge clk) disable iff (rst)
      clean_run |-> !bus_req.valid && !flow_valid)
      else begin fail_count++; $error("activity in a run after clear"); end

   a_clean_done: assert property (@(posedge clk) disable iff (rst) clean_run |-> ##[0:8] done)
      else begin fail_count++; $error("done did not return after a run on cleared registers"); end

endmodule

bind yolo_read yolo_read_sva sva0 (
   .clk        (clk),
   .rst        (rst),
   .clear      (clear),
   .run        (run),
   .cpu        (cpu),
   .bus_req    (bus_req),
   .bus_resp   (bus_resp),
   .flow_valid (flow_valid),
   .done       (done)
);

// File: yolo_read_tb.sv
`timescale 1ns/1ps
`include "yolo_read_macros.svh"

module yolo_read_tb import yolo_read_pkg::*; ();

   localparam logic [31:0] SEED        = 32'h75bce7c0;
   localparam logic [31:0] EXT_BASE    = 32'h0000_1000;
   localparam logic [31:0] LANE_OFFSET = 32'h0000_0240;
   localparam logic [31:0] BIAS_EXT    = 32'h0000_8000;
   localparam int          LEN         = 6;
   localparam int          INT_BASE    = 2;
   localparam int          ITER        = 3;
   localparam int          PER         = 4;
   localparam int          START       = 9;
   localparam int          SHIFT       = 5;
   localparam int          INCR        = 2;
   localparam int          BIAS_INT    = 1;
   localparam int          BIAS_START  = 3;
   // 200 cycles per transfer and read address plus room for setup and the clear run
   localparam int WATCHDOG_CYCLES = 200 * ((`N_VECT + 1) * LEN + ITER * PER) + 200 * 40;

   logic                                clk;
   logic                                rst;
   logic                                clear;
   logic                                run;
   cpu_wr_t                             cpu;
   bus_req_t                            bus_req;
   bus_resp_t                           bus_resp;
   logic [`N_VECT-1:0][`DATAPATH_W-1:0] flow_out_weight;
   logic [`DATABUS_W-1:0]               flow_out_bias;
   logic                                flow_valid;
   logic                                done;

   int          errors;
   int          xfer_count;
   int          valid_count;
   int          exp_addrs [$];
   int unsigned seen [bit [`EXT_ADDR_W-1:0]];

   yolo_read dut0 (
      .clk             (clk),
      .rst             (rst),
      .clear           (clear),
      .run             (run),
      .cpu             (cpu),
      .bus_req         (bus_req),
      .bus_resp        (bus_resp),
      .flow_out_weight (flow_out_weight),
      .flow_out_bias   (flow_out_bias),
      .flow_valid      (flow_valid),
      .done            (done)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired, the DUT did not return done in time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic report_error(input string msg);
      errors++;
      $display("[ERROR] %0t ns: %s", $time, msg);
   endtask

   // slot s of the word at a byte address holds the address plus s
   function automatic logic [`DATABUS_W-1:0] model_word(input logic [`EXT_ADDR_W-1:0] addr);
      logic [`DATABUS_W-1:0] w;
      for (int s = 0; s < `N_VECT; s++) begin
         w[s*`DATAPATH_W +: `DATAPATH_W] = addr + s;
      end
      return w;
   endfunction

   // lane memory word raddr/N_VECT came from fetch k = word - INT_BASE
   function automatic logic [`DATAPATH_W-1:0] weight_model(input int lane, input int raddr);
      int word_idx;
      int slot;
      word_idx = raddr / `N_VECT;
      slot     = raddr % `N_VECT;
      return EXT_BASE + lane * LANE_OFFSET + (word_idx - INT_BASE) * `BUS_BYTES + slot;
   endfunction

   // random gaps in ready and the transfer completes at the next rising edge
   initial begin
      logic grant;
      void'($urandom(SEED));
      forever begin
         @(negedge clk);
         grant = 1'b0;
         if (rst === 1'b0 && bus_req.valid) begin
            grant = ($urandom_range(0, 3) != 0);
         end
         bus_resp.ready <= grant;
         bus_resp.rdata <= model_word(bus_req.addr);
         if (grant) begin
            xfer_count++;
            seen[bus_req.addr] = seen[bus_req.addr] + 1;
         end
      end
   end

   always @(negedge clk) begin
      int a;
      if (!rst && flow_valid) begin
         valid_count++;
         assert (exp_addrs.size() > 0)
            else report_error("flow_valid seen with no read address left");
         if (exp_addrs.size() > 0) begin
            a = exp_addrs.pop_front();
            for (int i = 0; i < `N_VECT; i++) begin
               assert (flow_out_weight[i] == weight_model(i, a))
                  else report_error($sformatf("lane %0d addr %0d weight %h, expected %h",
                                              i, a, flow_out_weight[i], weight_model(i, a)));
            end
         end
      end
   end

   // called at a falling edge and returns at the next one
   task automatic write_reg(input logic [`CONF_ADDR_W-1:0] idx, input logic [31:0] value);
      cpu.valid = 1'b1;
      cpu.addr  = idx;
      cpu.wdata = value;
      @(negedge clk);
      cpu = '0;
   endtask

   task automatic run_and_wait();
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      assert (!done) else report_error("done still high in the cycle after run");
      while (!done) @(negedge clk);
   endtask

   task automatic check_fetch_addresses();
      logic [`EXT_ADDR_W-1:0] addr;
      for (int k = 0; k < LEN; k++) begin
         for (int i = 0; i <= `N_VECT; i++) begin
            if (i < `N_VECT) addr = EXT_BASE + i * LANE_OFFSET + k * `BUS_BYTES;
            else addr = BIAS_EXT + k * `BUS_BYTES;
            assert (seen.exists(addr) && seen[addr] == 1)
               else report_error($sformatf("address %h not fetched exactly once", addr));
         end
      end
      assert (seen.num() == (`N_VECT + 1) * LEN)
         else report_error($sformatf("%0d distinct addresses fetched", seen.num()));
   endtask

   task automatic check_bias();
      logic [`DATAPATH_W-1:0] exp;
      for (int j = 0; j < `N_VECT; j++) begin
         exp = BIAS_EXT + (BIAS_START - BIAS_INT) * `BUS_BYTES + (`N_VECT - 1 - j);
         assert (flow_out_bias[j*`DATAPATH_W +: `DATAPATH_W] == exp)
            else report_error($sformatf("bias lane %0d is %h, expected %h", j,
                                        flow_out_bias[j*`DATAPATH_W +: `DATAPATH_W], exp));
      end
   endtask

   initial begin
      int sva_fails;
      rst      = 1'b1;
      clear    = 1'b0;
      run      = 1'b0;
      cpu      = '0;
      bus_resp = '0;
      errors   = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      assert (done && !bus_req.valid) else report_error("DUT not idle after reset");

      write_reg(`CONF_EXT_ADDR, EXT_BASE);
      write_reg(`CONF_OFFSET, LANE_OFFSET);
      write_reg(`CONF_LEN, LEN);
      write_reg(`CONF_INT_ADDR, INT_BASE);
      write_reg(`CONF_ITER, ITER);
      write_reg(`CONF_PER, PER);
      write_reg(`CONF_START, START);
      write_reg(`CONF_SHIFT, SHIFT);
      write_reg(`CONF_INCR, INCR);
      write_reg(`CONF_BIAS_EXT_ADDR, BIAS_EXT);
      write_reg(`CONF_BIAS_INT_ADDR, BIAS_INT);
      write_reg(`CONF_BIAS_START, BIAS_START);

      // read order has iterations outside and period steps inside
      for (int j = 0; j < ITER; j++) begin
         for (int p = 0; p < PER; p++) begin
            exp_addrs.push_back((START + j * SHIFT + p * INCR) % (1 << `R_ADDR_W));
         end
      end
      xfer_count  = 0;
      valid_count = 0;
      run_and_wait();
      assert (xfer_count == (`N_VECT + 1) * LEN)
         else report_error($sformatf("%0d transfers, expected %0d", xfer_count,
                                     (`N_VECT + 1) * LEN));
      assert (valid_count == ITER * PER)
         else report_error($sformatf("%0d flow_valid pulses, expected %0d", valid_count,
                                     ITER * PER));
      check_fetch_addresses();
      check_bias();

      // cleared registers give an empty run
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      xfer_count  = 0;
      valid_count = 0;
      run_and_wait();
      assert (xfer_count == 0 && valid_count == 0)
         else report_error("bus or flow activity after clear");
      repeat (4) @(negedge clk);

      sva_fails = dut0.sva0.fail_count;
      $display("errors: %0d testbench checks, %0d assertion failures", errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
